/* common/csr_pkg.sv */
// register address enum, message writer state enum, message word type
package csr_pkg;

`include "imgproc_macros.svh"

  // cpu visible registers
  typedef enum logic [2:0] {
    ADDR_STATUS = `REG_STATUS,
    ADDR_MSG = `REG_MSG,
    ADDR_ID = `REG_ID,
    ADDR_BBCOL = `REG_BBCOL
  } reg_addr_e;

  // message writer sequence, one word per state
  typedef enum logic [1:0] {
    MSG_IDLE = 2'd0,
    MSG_ID = 2'd1,
    MSG_TOP_LEFT = 2'd2,
    MSG_BOTTOM_RIGHT = 2'd3
  } msg_state_e;

  // one message fifo entry
  typedef logic [31:0] msg_word_t;

endpackage

/* common/imgproc_ifs.sv */
// box_if and msg_if interfaces with their modports
`timescale 1ns/1ps
`include "imgproc_macros.svh"

////////////////////////////////////////////////////////////
// latched bounding box of the previous video frame
interface box_if;
  video_pkg::coord_t left;
  video_pkg::coord_t right;
  video_pkg::coord_t top;
  video_pkg::coord_t bottom;
  // single cycle, accepted eop of a video packet
  logic frame_done;

  modport tracker (output left, right, top, bottom, frame_done);
  modport overlay (input left, right, top, bottom);
  modport writer (input left, right, top, bottom, frame_done);
endinterface

////////////////////////////////////////////////////////////
// message fifo port, shared by writer, fifo and csr
interface msg_if;
  // push side
  logic wr;
  csr_pkg::msg_word_t wdata;
  // pop side
  logic rd;
  logic flush;
  // show-ahead head word
  csr_pkg::msg_word_t q;
  logic [`MSG_LEVEL_W-1:0] used;
  logic empty;

  modport writer (output wr, wdata, input used);
  modport fifo (input wr, wdata, rd, flush, output q, used, empty);
  modport csr (output rd, flush, input q, used, empty);
endinterface

/* common/imgproc_macros.svh */
// frame size, message interval, fifo depth, register map, id and default colour constants
`ifndef IMGPROC_MACROS_SVH
`define IMGPROC_MACROS_SVH

////////////////////////////////////////////////////////////
// frame geometry in pixels
`define IMG_W 640
`define IMG_H 480

////////////////////////////////////////////////////////////
// message path
// frames between two box messages
`define MSG_INTERVAL 6
`define MSG_FIFO_DEPTH 256
// fill level width, holds 0 up to the full depth
`define MSG_LEVEL_W 9
// ascii "RBB", first word of each message
`define RED_BOX_MSG_ID {8'h00, "RBB"}

////////////////////////////////////////////////////////////
// register map on the 3-bit address bus
`define REG_STATUS 3'd0
`define REG_MSG 3'd1
`define REG_ID 3'd2
`define REG_BBCOL 3'd3

`define DEVICE_ID 32'h1234_EEE2
// green box after reset
`define BB_COL_DEFAULT 24'h00ff00

`endif

/* common/video_pkg.sv */
// video path types: coordinate, rgb pixel, stream beat, red pixel test
package video_pkg;

  // pixel coordinate, covers 0..2047
  typedef logic [10:0] coord_t;

  // red in the top byte, blue in the bottom byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  // one stream beat with packet flags
  typedef struct packed {
    pixel_t pix;
    logic sop;
    logic eop;
  } beat_t;

  // strongly red: red msb set, green and blue msb clear
  function automatic logic is_red(pixel_t p);
    return p.r[7] & ~p.g[7] & ~p.b[7];
  endfunction

endpackage

/* hdl/eee_imgproc.sv */
// top level: stream registers, red box tracker, overlay, message path and registers
`timescale 1ns/1ps
`include "imgproc_macros.svh"

module eee_imgproc (
  input logic clk,
  input logic reset_n,
  // cpu slave port
  input logic s_chipselect,
  input logic s_read,
  input logic s_write,
  input logic [2:0] s_address,
  input logic [31:0] s_writedata,
  output logic [31:0] s_readdata,
  // video in
  input logic [23:0] sink_data,
  input logic sink_valid,
  output logic sink_ready,
  input logic sink_sop,
  input logic sink_eop,
  // video out
  output logic [23:0] source_data,
  output logic source_valid,
  input logic source_ready,
  output logic source_sop,
  output logic source_eop,
  // filter enable
  input logic mode
);

  video_pkg::beat_t sink_beat, in_beat, ovl_beat, source_beat;
  video_pkg::coord_t x, y;
  video_pkg::pixel_t bb_col;
  logic in_valid, out_ready, packet_video;

  box_if box ();
  msg_if msg ();

  // pack and unpack at the ports
  assign sink_beat = '{pix: sink_data, sop: sink_sop, eop: sink_eop};
  assign source_data = source_beat.pix;
  assign source_sop = source_beat.sop;
  assign source_eop = source_beat.eop;

  ////////////////////////////////////////////////////////////
  // stream path

  stream_reg in_reg (
    .clk(clk), .reset_n(reset_n),
    .valid_in(sink_valid), .ready_out(sink_ready), .data_in(sink_beat),
    .valid_out(in_valid), .ready_in(out_ready), .data_out(in_beat)
  );

  red_box_tracker tracker (
    .clk(clk), .reset_n(reset_n), .beat(in_beat), .valid(in_valid),
    .ready(out_ready), .x(x), .y(y), .packet_video(packet_video), .box(box.tracker)
  );

  pixel_overlay overlay (
    .beat_in(in_beat), .x(x), .y(y), .packet_video(packet_video), .mode(mode),
    .bb_col(bb_col), .box(box.overlay), .beat_out(ovl_beat)
  );

  stream_reg out_reg (
    .clk(clk), .reset_n(reset_n),
    .valid_in(in_valid), .ready_out(out_ready), .data_in(ovl_beat),
    .valid_out(source_valid), .ready_in(source_ready), .data_out(source_beat)
  );

  ////////////////////////////////////////////////////////////
  // message path and registers

  msg_writer writer (.clk(clk), .reset_n(reset_n), .box(box.writer), .msg(msg.writer));

  msg_fifo #(.DEPTH(`MSG_FIFO_DEPTH)) fifo (.clk(clk), .reset_n(reset_n), .msg(msg.fifo));

  imgproc_csr csr (
    .clk(clk), .reset_n(reset_n), .chipselect(s_chipselect), .read(s_read),
    .write(s_write), .address(s_address), .writedata(s_writedata),
    .readdata(s_readdata), .bb_col(bb_col), .msg(msg.csr)
  );

endmodule

/* hdl/imgproc_csr.sv */
// memory-mapped registers: status, flush, box colour, id and message pops
`timescale 1ns/1ps
`include "imgproc_macros.svh"

module imgproc_csr (
  input logic clk,
  input logic reset_n,
  // cpu slave port
  input logic chipselect,
  input logic read,
  input logic write,
  input logic [2:0] address,
  input logic [31:0] writedata,
  output logic [31:0] readdata,
  // box colour to the overlay
  output video_pkg::pixel_t bb_col,
  msg_if.csr msg
);

  csr_pkg::reg_addr_e addr;
  logic [7:0] status;
  logic read_d;
  logic rd_cs;
  logic wr_cs;

  assign addr = csr_pkg::reg_addr_e'(address);
  assign rd_cs = chipselect & read;
  assign wr_cs = chipselect & write;

  // status bit 4 clears the message fifo
  assign msg.flush = wr_cs & (addr == csr_pkg::ADDR_STATUS) & writedata[4];

  // pop on the first cycle of a message read only
  assign msg.rd = rd_cs & ~read_d & ~msg.empty & (addr == csr_pkg::ADDR_MSG);

  ////////////////////////////////////////////////////////////
  // writes

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      status <= '0;
      bb_col <= video_pkg::pixel_t'(`BB_COL_DEFAULT);
    end else if (wr_cs) begin
      if (addr == csr_pkg::ADDR_STATUS) status <= writedata[7:0];
      if (addr == csr_pkg::ADDR_BBCOL) bb_col <= writedata[23:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // reads, one cycle latency

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      readdata <= '0;
      read_d <= 1'b0;
    end else begin
      read_d <= read;
      if (rd_cs) begin
        case (addr)
          // level in bits 16:8
          csr_pkg::ADDR_STATUS: readdata <= {15'b0, msg.used, status};
          csr_pkg::ADDR_MSG: readdata <= msg.q;
          csr_pkg::ADDR_ID: readdata <= `DEVICE_ID;
          csr_pkg::ADDR_BBCOL: readdata <= {8'h00, bb_col};
          default: readdata <= '0;
        endcase
      end
    end
  end

endmodule

/* hdl/stream_reg.sv */
// one-entry valid/ready pipeline register for stream beats
`timescale 1ns/1ps

module stream_reg (
  input logic clk,
  input logic reset_n,
  // upstream side
  input logic valid_in,
  output logic ready_out,
  input video_pkg::beat_t data_in,
  // downstream side
  output logic valid_out,
  input logic ready_in,
  output video_pkg::beat_t data_out
);

  // take a new beat when empty or when the held one leaves now
  assign ready_out = ~valid_out | ready_in;

  // occupancy flag
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_out <= 1'b0;
    end else if (ready_out) begin
      valid_out <= valid_in;
    end
  end

  // payload
  // held stable while downstream stalls
  always_ff @(posedge clk) begin
    if (ready_out && valid_in) begin
      data_out <= data_in;
    end
  end

endmodule

/* msg/msg_fifo.sv */
// synchronous show-ahead message FIFO with fill level, empty flag and clear
`timescale 1ns/1ps
`include "imgproc_macros.svh"

module msg_fifo #(
  parameter int DEPTH = 256
) (
  input logic clk,
  input logic reset_n,
  msg_if.fifo msg
);

  localparam int AW = $clog2(DEPTH);

  csr_pkg::msg_word_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [`MSG_LEVEL_W-1:0] count;
  logic push;
  logic pop;

  // drop writes when full, ignore reads when empty
  assign push = msg.wr & (count != `MSG_LEVEL_W'(DEPTH));
  assign pop = msg.rd & ~msg.empty;

  // head word always visible
  assign msg.q = mem[rd_ptr];
  assign msg.used = count;
  assign msg.empty = (count == '0);

  ////////////////////////////////////////////////////////////
  // pointers and level

  always_ff @(posedge clk) begin
    if (!reset_n || msg.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // level unchanged on push and pop together
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= msg.wdata;
    end
  end

endmodule

/* msg/msg_writer.sv */
// frame interval counter and three-word box message FSM
`timescale 1ns/1ps
`include "imgproc_macros.svh"

module msg_writer (
  input logic clk,
  input logic reset_n,
  box_if.writer box,
  msg_if.writer msg
);

  csr_pkg::msg_state_e state;
  logic [7:0] frame_cnt;
  logic room;

  // room for a whole message
  assign room = msg.used < `MSG_LEVEL_W'(`MSG_FIFO_DEPTH - 3);

  ////////////////////////////////////////////////////////////
  // interval counter and sequence

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= csr_pkg::MSG_IDLE;
      frame_cnt <= '0;
    end else begin
      case (state)
        csr_pkg::MSG_ID: state <= csr_pkg::MSG_TOP_LEFT;
        csr_pkg::MSG_TOP_LEFT: state <= csr_pkg::MSG_BOTTOM_RIGHT;
        csr_pkg::MSG_BOTTOM_RIGHT: state <= csr_pkg::MSG_IDLE;
        default: state <= csr_pkg::MSG_IDLE;
      endcase
      if (box.frame_done) begin
        if (frame_cnt == 8'd0 && room) begin
          state <= csr_pkg::MSG_ID;
          frame_cnt <= 8'(`MSG_INTERVAL - 1);
        end else if (frame_cnt != 8'd0) begin
          // held at zero while the fifo is too full
          frame_cnt <= frame_cnt - 8'd1;
        end
      end
    end
  end

  // one word per active state
  always_comb begin
    msg.wr = 1'b1;
    case (state)
      csr_pkg::MSG_ID: msg.wdata = `RED_BOX_MSG_ID;
      csr_pkg::MSG_TOP_LEFT: msg.wdata = {5'b0, box.left, 5'b0, box.top};
      csr_pkg::MSG_BOTTOM_RIGHT: msg.wdata = {5'b0, box.right, 5'b0, box.bottom};
      default: begin
        msg.wr = 1'b0;
        msg.wdata = '0;
      end
    endcase
  end

endmodule

/* project.f */
+incdir+common
common/video_pkg.sv
common/csr_pkg.sv
common/imgproc_ifs.sv
hdl/stream_reg.sv
tracker/red_box_tracker.sv
tracker/pixel_overlay.sv
msg/msg_writer.sv
msg/msg_fifo.sv
hdl/imgproc_csr.sv
hdl/eee_imgproc.sv
testbench/tb_clock.sv
testbench/tb_imgproc.sv

/* testbench/tb_clock.sv */
// testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset low over 5 rising edges, released on a falling edge
  initial begin
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

/* testbench/tb_imgproc.sv */
// testbench top with reference model, lfsr, value check and directed tests for eee_imgproc
`timescale 1ns/1ps
`include "imgproc_macros.svh"

module tb_imgproc;

  // one full frame is sop plus two rows
  localparam int FULL_BEATS = 2 * `IMG_W + 1;
  // about nine full frames incl. a stalled one at half rate plus short frames
  localparam int CYCLE_LIMIT = 12 * FULL_BEATS + 1000;

  logic clk, reset_n;
  logic s_chipselect, s_read, s_write;
  logic [2:0] s_address;
  logic [31:0] s_writedata, s_readdata;
  logic [23:0] sink_data, source_data;
  logic sink_valid, sink_ready, sink_sop, sink_eop;
  logic source_valid, source_ready, source_sop, source_eop;
  logic mode;

  // stimulus and collected output
  video_pkg::pixel_t frame_px[$];
  video_pkg::beat_t sent_q[$];
  video_pkg::beat_t exp_q[$];
  video_pkg::beat_t out_q[$];
  logic stall;
  logic [31:0] lfsr;
  int errors;
  int checks;
  int cycle_cnt = 0;
  // beats taken by the sink and not yet out of the source
  int in_flight;

  // model state
  int box_l, box_r, box_t, box_b;
  int model_cnt;
  logic [31:0] fifo_m[$];
  logic [23:0] bb_col_m;
  logic [7:0] model_status;

  tb_clock clock_gen (.clk(clk), .reset_n(reset_n));

  eee_imgproc i_dut (
    .clk(clk), .reset_n(reset_n),
    .s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
    .s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
    .sink_data(sink_data), .sink_valid(sink_valid), .sink_ready(sink_ready),
    .sink_sop(sink_sop), .sink_eop(sink_eop),
    .source_data(source_data), .source_valid(source_valid),
    .source_ready(source_ready), .source_sop(source_sop), .source_eop(source_eop),
    .mode(mode)
  );

  ////////////////////////////////////////////////////////////
  // watchdog

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("TIMEOUT: run did not finish within %0d cycles", CYCLE_LIMIT);
      errors = errors + 1;
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // galois lfsr random bits

  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // position of pixel (x, y) in the output queue
  function automatic int beat_index(input int x, input int y);
    return 1 + y * `IMG_W + x;
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model of one packet

  task automatic model_frame(input logic [23:0] desc);
    int i, x, y, xmin, xmax, ymin, ymax;
    logic red, video, on_box;
    logic [7:0] grey;
    video_pkg::pixel_t p, o;
    video_pkg::beat_t b;
    video = (desc[3:0] == 4'h0);
    exp_q.delete();
    sent_q.delete();
    b.pix = desc;
    b.sop = 1'b1;
    b.eop = 1'b0;
    // descriptor beat never altered
    exp_q.push_back(b);
    sent_q.push_back(b);
    x = 0;
    y = 0;
    xmin = `IMG_W - 1;
    ymin = `IMG_H - 1;
    xmax = 0;
    ymax = 0;
    for (i = 0; i < frame_px.size(); i++) begin
      p = frame_px[i];
      red = p.r[7] && !p.g[7] && !p.b[7];
      grey = (p.g >> 1) + (p.r >> 2) + (p.b >> 2);
      o = p;
      if (mode && video) begin
        // box of the previous frame wins
        on_box = (x == box_l) || (x == box_r) || (y == box_t) || (y == box_b);
        if (on_box) o = bb_col_m;
        else if (red) o = 24'hff0000;
        else o = {grey, grey, grey};
      end
      if (red) begin
        if (x < xmin) xmin = x;
        if (x > xmax) xmax = x;
        if (y < ymin) ymin = y;
        if (y > ymax) ymax = y;
      end
      if (x == `IMG_W - 1) begin
        x = 0;
        y = y + 1;
      end else begin
        x = x + 1;
      end
      b.sop = 1'b0;
      b.eop = (i == frame_px.size() - 1);
      b.pix = p;
      sent_q.push_back(b);
      b.pix = o;
      exp_q.push_back(b);
    end
    if (video) begin
      box_l = xmin;
      box_r = xmax;
      box_t = ymin;
      box_b = ymax;
      // message every MSG_INTERVAL video frames while room is left
      if (model_cnt == 0 && fifo_m.size() < `MSG_FIFO_DEPTH - 3) begin
        fifo_m.push_back(`RED_BOX_MSG_ID);
        fifo_m.push_back((box_l << 16) | box_t);
        fifo_m.push_back((box_r << 16) | box_b);
        model_cnt = `MSG_INTERVAL - 1;
      end else if (model_cnt != 0) begin
        model_cnt = model_cnt - 1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stream driver for one clock

  task automatic tick(input logic vld, input video_pkg::beat_t b, output logic took);
    video_pkg::beat_t o;
    @(negedge clk);
    sink_valid = vld;
    sink_data = b.pix;
    sink_sop = b.sop;
    sink_eop = b.eop;
    source_ready = stall ? next_bit() : 1'b1;
    // all handshake signals settled well before the rising edge
    #1;
    // sink stalls only with both stages full and the output stalled
    check_eq(sink_ready, !(in_flight == 2 && !source_ready), "sink_ready");
    took = vld & sink_ready;
    if (took) in_flight = in_flight + 1;
    if (source_valid && source_ready) begin
      o.pix = source_data;
      o.sop = source_sop;
      o.eop = source_eop;
      out_q.push_back(o);
      in_flight = in_flight - 1;
    end
  endtask

  task automatic fill_frame(input int npix, input logic allow_red);
    int i;
    logic [31:0] v;
    video_pkg::pixel_t p;
    frame_px.delete();
    for (i = 0; i < npix; i++) begin
      v = rand_bits(24);
      p = v[23:0];
      if (!allow_red) p.r[7] = 1'b0;
      frame_px.push_back(p);
    end
  endtask

  // model, send, drain and compare frame_px behind descriptor desc
  // stall is cleared once the expected beats are out
  task automatic run_frame(input logic [23:0] desc);
    int i;
    logic took;
    video_pkg::beat_t idle;
    idle = '0;
    model_frame(desc);
    out_q.delete();
    for (i = 0; i < sent_q.size(); i++) begin
      took = 1'b0;
      while (!took) tick(1'b1, sent_q[i], took);
    end
    while (out_q.size() < exp_q.size()) tick(1'b0, idle, took);
    stall = 1'b0;
    // extra cycles expose duplicated beats
    repeat (4) tick(1'b0, idle, took);
    check_eq(out_q.size(), exp_q.size(), "output beat count");
    for (i = 0; i < out_q.size() && i < exp_q.size(); i++) begin
      check_eq(out_q[i], exp_q[i], $sformatf("output beat %0d", i));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // register access

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk);
    s_chipselect = 1'b1;
    s_write = 1'b1;
    s_address = addr;
    s_writedata = data;
    @(negedge clk);
    s_chipselect = 1'b0;
    s_write = 1'b0;
  endtask

  // readdata registered and sampled one cycle after the strobe
  // strobe held a second cycle, a message read still pops once
  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    @(negedge clk);
    s_chipselect = 1'b1;
    s_read = 1'b1;
    s_address = addr;
    @(negedge clk);
    data = s_readdata;
    @(negedge clk);
    s_chipselect = 1'b0;
    s_read = 1'b0;
  endtask

  task automatic check_status(output int level);
    logic [31:0] d;
    read_reg(`REG_STATUS, d);
    level = d[16:8];
    check_eq(level, fifo_m.size(), "fifo level");
    check_eq(d[7:0], model_status, "status byte");
  endtask

  task automatic pop_msg(output logic [31:0] word);
    read_reg(`REG_MSG, word);
    if (fifo_m.size() > 0) check_eq(word, fifo_m.pop_front(), "message word");
  endtask

  task automatic flush_fifo();
    write_reg(`REG_STATUS, 32'h10);
    model_status = 8'h10;
    fifo_m.delete();
  endtask

  // short video packets until the frame counter is back at zero
  task automatic align_interval();
    while (model_cnt != 0) begin
      fill_frame(4, 1'b0);
      run_frame(24'h0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic highlight_test();
    int level;
    check_eq(s_readdata, 32'h0, "readdata after reset");
    check_status(level);
    check_eq(level, 0, "level after reset");
    mode = 1'b1;
    fill_frame(2 * `IMG_W, 1'b1);
    frame_px[640 + 10] = 24'h80_10_20;
    frame_px[640 + 11] = 24'h40_80_20;
    run_frame(24'h0);
    // box still zero, so row 0 and column 0 are box lines
    check_eq(out_q[beat_index(3, 0)].pix, `BB_COL_DEFAULT, "row 0 box line");
    check_eq(out_q[beat_index(0, 1)].pix, `BB_COL_DEFAULT, "column 0 box line");
    check_eq(out_q[beat_index(10, 1)].pix, 24'hff0000, "red highlight");
    check_eq(out_q[beat_index(11, 1)].pix, 24'h585858, "grey pixel");
  endtask

  task automatic passthrough_test();
    int i;
    mode = 1'b0;
    fill_frame(2 * `IMG_W, 1'b1);
    run_frame(24'h0);
    for (i = 0; i < out_q.size() && i < sent_q.size(); i++) begin
      check_eq(out_q[i], sent_q[i], "mode low beat");
    end
    // descriptor nibble 5 marks a non-video packet
    mode = 1'b1;
    fill_frame(2 * `IMG_W, 1'b1);
    run_frame(24'h000005);
    for (i = 0; i < out_q.size() && i < sent_q.size(); i++) begin
      check_eq(out_q[i], sent_q[i], "non-video beat");
    end
  endtask

  task automatic box_message_test();
    int level;
    logic [31:0] w;
    align_interval();
    flush_fifo();
    mode = 1'b1;
    // red only in row 1 gives columns 100 to 400 on row 1
    fill_frame(2 * `IMG_W, 1'b0);
    frame_px[640 + 100] = 24'hc0_20_30;
    frame_px[640 + 250] = 24'hc0_20_30;
    frame_px[640 + 400] = 24'hc0_20_30;
    run_frame(24'h0);
    fill_frame(2 * `IMG_W, 1'b0);
    run_frame(24'h0);
    check_eq(out_q[beat_index(100, 0)].pix, `BB_COL_DEFAULT, "left box line");
    check_eq(out_q[beat_index(400, 0)].pix, `BB_COL_DEFAULT, "right box line");
    check_eq(out_q[beat_index(7, 1)].pix, `BB_COL_DEFAULT, "top/bottom box line");
    check_status(level);
    check_eq(level, 3, "level after one message");
    pop_msg(w);
    check_eq(w, 32'h0052_4242, "message id word");
    pop_msg(w);
    check_eq(w, 32'h0064_0001, "left/top word");
    pop_msg(w);
    check_eq(w, 32'h0190_0001, "right/bottom word");
  endtask

  task automatic interval_test();
    int i, level;
    align_interval();
    flush_fifo();
    for (i = 0; i < `MSG_INTERVAL + 1; i++) begin
      fill_frame(6, 1'b1);
      run_frame(24'h0);
    end
    check_status(level);
    check_eq(level, 6, "level after interval");
  endtask

  task automatic register_test();
    int level;
    logic [31:0] d;
    read_reg(`REG_ID, d);
    check_eq(d, 32'h1234_EEE2, "device id");
    d = rand_bits(24);
    write_reg(`REG_BBCOL, d);
    bb_col_m = d[23:0];
    read_reg(`REG_BBCOL, d);
    check_eq(d, {8'h00, bb_col_m}, "box colour readback");
    mode = 1'b1;
    fill_frame(2 * `IMG_W, 1'b1);
    run_frame(24'h0);
    // row 0 lies on the bottom line left by the short frames
    check_eq(out_q[beat_index(20, 0)].pix, bb_col_m, "new box colour");
    flush_fifo();
    check_status(level);
    check_eq(level, 0, "level after flush");
  endtask

  task automatic backpressure_test();
    mode = 1'b1;
    stall = 1'b1;
    fill_frame(2 * `IMG_W, 1'b1);
    run_frame(24'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    s_chipselect = 1'b0;
    s_read = 1'b0;
    s_write = 1'b0;
    s_address = '0;
    s_writedata = '0;
    sink_data = '0;
    sink_valid = 1'b0;
    sink_sop = 1'b0;
    sink_eop = 1'b0;
    source_ready = 1'b1;
    mode = 1'b0;
    stall = 1'b0;
    lfsr = 32'h3099_8986;
    errors = 0;
    checks = 0;
    in_flight = 0;
    box_l = 0;
    box_r = 0;
    box_t = 0;
    box_b = 0;
    model_cnt = 0;
    bb_col_m = `BB_COL_DEFAULT;
    model_status = 8'h00;
    @(posedge reset_n);
    // first video frame after reset must come first
    highlight_test();
    passthrough_test();
    box_message_test();
    interval_test();
    register_test();
    backpressure_test();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tracker/pixel_overlay.sv */
// grey conversion, red highlight and bounding box lines for one beat
`timescale 1ns/1ps

module pixel_overlay (
  input video_pkg::beat_t beat_in,
  input video_pkg::coord_t x,
  input video_pkg::coord_t y,
  input logic packet_video,
  input logic mode,
  input video_pkg::pixel_t bb_col,
  box_if.overlay box,
  output video_pkg::beat_t beat_out
);

  logic [7:0] grey;
  logic on_box;
  video_pkg::pixel_t high_pix;
  video_pkg::pixel_t new_pix;

  // grey = g/2 + r/4 + b/4, max 253
  assign grey = {1'b0, beat_in.pix.g[7:1]} + {2'b00, beat_in.pix.r[7:2]}
              + {2'b00, beat_in.pix.b[7:2]};

  // red stays pure red, everything else grey
  assign high_pix = video_pkg::is_red(beat_in.pix) ? '{r: 8'hff, g: 8'h00, b: 8'h00}
                                                    : '{r: grey, g: grey, b: grey};

  // any of the four box lines
  assign on_box = (x == box.left) | (x == box.right) | (y == box.top) | (y == box.bottom);

  // box lines win over the highlight
  assign new_pix = on_box ? bb_col : high_pix;

  // sop carries the packet descriptor, leave it alone
  always_comb begin
    beat_out = beat_in;
    if (mode && !beat_in.sop && packet_video) begin
      beat_out.pix = new_pix;
    end
  end

endmodule

/* tracker/red_box_tracker.sv */
// beat coordinate counter, packet type flag, red detection and bounding box latch
`timescale 1ns/1ps
`include "imgproc_macros.svh"

module red_box_tracker (
  input logic clk,
  input logic reset_n,
  // beat at the input register output
  input video_pkg::beat_t beat,
  input logic valid,
  input logic ready,
  // coordinates of the current beat
  output video_pkg::coord_t x,
  output video_pkg::coord_t y,
  output logic packet_video,
  box_if.tracker box
);

  logic accept;
  logic red_pix;
  video_pkg::coord_t x_min, x_max, y_min, y_max;
  video_pkg::coord_t x_min_nxt, x_max_nxt, y_min_nxt, y_max_nxt;

  // beat moves into the output stage
  assign accept = valid & ready;
  assign red_pix = video_pkg::is_red(beat.pix);

  // end of a video frame
  assign box.frame_done = accept & beat.eop & packet_video;

  ////////////////////////////////////////////////////////////
  // coordinate counter

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      x <= '0;
      y <= '0;
      packet_video <= 1'b0;
    end else if (accept) begin
      if (beat.sop) begin
        x <= '0;
        y <= '0;
        // descriptor nibble 0 marks video
        packet_video <= (beat.pix.b[3:0] == 4'h0);
      end else if (x == video_pkg::coord_t'(`IMG_W - 1)) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bounds, including the current pixel

  always_comb begin
    x_min_nxt = x_min;
    x_max_nxt = x_max;
    y_min_nxt = y_min;
    y_max_nxt = y_max;
    if (red_pix) begin
      if (x < x_min) x_min_nxt = x;
      if (x > x_max) x_max_nxt = x;
      if (y < y_min) y_min_nxt = y;
      if (y > y_max) y_max_nxt = y;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || (accept && beat.sop)) begin
      // empty box, min above max
      x_min <= video_pkg::coord_t'(`IMG_W - 1);
      y_min <= video_pkg::coord_t'(`IMG_H - 1);
      x_max <= '0;
      y_max <= '0;
    end else if (accept) begin
      x_min <= x_min_nxt;
      x_max <= x_max_nxt;
      y_min <= y_min_nxt;
      y_max <= y_max_nxt;
    end
  end

  // latch for the overlay of the next frame
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      box.left <= '0;
      box.right <= '0;
      box.top <= '0;
      box.bottom <= '0;
    end else if (box.frame_done) begin
      box.left <= x_min_nxt;
      box.right <= x_max_nxt;
      box.top <= y_min_nxt;
      box.bottom <= y_max_nxt;
    end
  end

endmodule
